//--- rtl/pcs_sync_pkg.sv
/* Valid table is a 1000BASE-X subset only (D0.0-D9.0, D5.6, D16.2, K23.7, K27.7, K29.7).
   Code groups are written abcdei_fghj with bit 9 as a. */
package pcs_sync_pkg;

    // 10-bit code group as seen on the wire
    typedef logic [9:0] cg_t;

    // Even flag on top of the code group
    typedef struct packed {
        logic even;
        cg_t  code_group;
    } sudi_t;

    // ============================================================
    // Code-group constants
    // ============================================================

    // Comma character
    localparam cg_t k28_5_rdn  = 10'b001111_1010;
    localparam cg_t k28_5_rdp  = 10'b110000_0101;

    // D0.0 to D9.0
    localparam cg_t d0_0_rdn   = 10'b100111_0100;
    localparam cg_t d0_0_rdp   = 10'b011000_1011;
    localparam cg_t d1_0_rdn   = 10'b011101_0100;
    localparam cg_t d1_0_rdp   = 10'b100010_1011;
    localparam cg_t d2_0_rdn   = 10'b101101_0100;
    localparam cg_t d2_0_rdp   = 10'b010010_1011;
    localparam cg_t d3_0_rdn   = 10'b110001_1011;
    localparam cg_t d3_0_rdp   = 10'b110001_0100;
    localparam cg_t d4_0_rdn   = 10'b110101_0100;
    localparam cg_t d4_0_rdp   = 10'b001010_1011;
    localparam cg_t d5_0_rdn   = 10'b101001_1011;
    localparam cg_t d5_0_rdp   = 10'b101001_0100;
    localparam cg_t d6_0_rdn   = 10'b011001_1011;
    localparam cg_t d6_0_rdp   = 10'b011001_0100;
    localparam cg_t d7_0_rdn   = 10'b111000_1011;
    localparam cg_t d7_0_rdp   = 10'b000111_0100;
    localparam cg_t d8_0_rdn   = 10'b111001_0100;
    localparam cg_t d8_0_rdp   = 10'b000110_1011;
    localparam cg_t d9_0_rdn   = 10'b100101_1011;
    localparam cg_t d9_0_rdp   = 10'b100101_0100;

    // Neutral in both halves so both forms match
    localparam cg_t d5_6_rdn   = 10'b101001_0110;
    localparam cg_t d5_6_rdp   = 10'b101001_0110;

    localparam cg_t d16_2_rdn  = 10'b011011_0101;
    localparam cg_t d16_2_rdp  = 10'b100100_0101;

    // Control characters K23.7, K27.7, K29.7
    localparam cg_t k23_7_rdn  = 10'b111010_1000;
    localparam cg_t k23_7_rdp  = 10'b000101_0111;
    localparam cg_t k27_7_rdn  = 10'b110110_1000;
    localparam cg_t k27_7_rdp  = 10'b001001_0111;
    localparam cg_t k29_7_rdn  = 10'b101110_1000;
    localparam cg_t k29_7_rdp  = 10'b010001_0111;

    // Table scanned by the classifier
    localparam int  valid_table_len = 30;
    localparam cg_t valid_table [valid_table_len] = '{
        d0_0_rdn,  d0_0_rdp,  d1_0_rdn,  d1_0_rdp,
        d2_0_rdn,  d2_0_rdp,  d3_0_rdn,  d3_0_rdp,
        d4_0_rdn,  d4_0_rdp,  d5_0_rdn,  d5_0_rdp,
        d6_0_rdn,  d6_0_rdp,  d7_0_rdn,  d7_0_rdp,
        d8_0_rdn,  d8_0_rdp,  d9_0_rdn,  d9_0_rdp,
        d5_6_rdn,  d5_6_rdp,  d16_2_rdn, d16_2_rdp,
        k23_7_rdn, k23_7_rdp, k27_7_rdn, k27_7_rdp,
        k29_7_rdn, k29_7_rdp
    };

    // ============================================================
    // Classes, states and counters
    // ============================================================

    // Class of one code group
    typedef enum logic [1:0] {
        cg_comma,
        cg_valid,
        cg_invalid
    } cg_kind_t;

    // Clause 36 synchronization states
    typedef enum logic [3:0] {
        loss_of_sync,
        comma_detect_1,
        acquire_sync_1,
        comma_detect_2,
        acquire_sync_2,
        comma_detect_3,
        sync_acquired_1,
        sync_acquired_2,
        sync_acquired_2a,
        sync_acquired_3,
        sync_acquired_3a,
        sync_acquired_4,
        sync_acquired_4a
    } sync_state_t;

    // Good code groups that undo one error
    localparam int good_cgs_w      = 3;
    localparam int good_cgs_needed = 4;

    typedef logic [good_cgs_w-1:0] good_cnt_t;

    // Count value seen on the last good code group of a run
    localparam good_cnt_t good_cgs_last = good_cgs_w'(good_cgs_needed - 1);

endpackage

//--- rtl/cg_classify.sv
`timescale 1ns/1ns

/* Purely combinational; running disparity is not tracked, either form is accepted.
   Anything outside the package table and not K28.5 is reported invalid. */
module cg_classify (
    input  pcs_sync_pkg::cg_t      code_group,
    output pcs_sync_pkg::cg_kind_t kind
);

    // Hit flags from the two compare stages
    logic is_comma;
    logic in_table;

    // ============================================================
    // Comma compare
    // ============================================================

    // K28.5 in either running disparity
    assign is_comma = (code_group == pcs_sync_pkg::k28_5_rdn) ||
                      (code_group == pcs_sync_pkg::k28_5_rdp);

    // ============================================================
    // Valid table scan
    // ============================================================

    // Unrolled into a flat OR of equality compares
    always_comb begin
        in_table = 1'b0;
        for (int i = 0; i < pcs_sync_pkg::valid_table_len; i++) begin
            if (code_group == pcs_sync_pkg::valid_table[i]) begin
                in_table = 1'b1;
            end
        end
    end

    // Comma wins, the table never holds K28.5 anyway
    always_comb begin
        if (is_comma) begin
            kind = pcs_sync_pkg::cg_comma;
        end
        else if (in_table) begin
            kind = pcs_sync_pkg::cg_valid;
        end
        else begin
            // Disparity errors and unknown codes land here
            kind = pcs_sync_pkg::cg_invalid;
        end
    end

endmodule

//--- rtl/sync_fsm.sv
`timescale 1ns/1ns

/* One classified code group per rx_clk, no stall. Any comma starts acquisition in
   loss_of_sync; later commas count only in an even position. */
module sync_fsm (
    input  logic                   rx_clk,
    input  logic                   reset,
    input  pcs_sync_pkg::cg_kind_t kind,
    output logic                   rx_even,
    output logic                   sync_status
);

    // State register and its next values
    pcs_sync_pkg::sync_state_t state;
    pcs_sync_pkg::sync_state_t next_state;
    logic                      next_rx_even;
    logic                      next_sync_status;
    pcs_sync_pkg::good_cnt_t   good_cgs;
    pcs_sync_pkg::good_cnt_t   next_good_cgs;

    // Decoded conditions on the current code group
    logic any_comma;
    logic even_comma;
    logic data_ok;
    logic cg_good;
    logic run_done;

    assign any_comma  = (kind == pcs_sync_pkg::cg_comma);
    assign even_comma = any_comma && rx_even;
    assign data_ok    = (kind == pcs_sync_pkg::cg_valid);

    // Odd comma is bad, even comma is good
    assign cg_good    = data_ok || even_comma;

    // This good code group completes a run of four
    assign run_done   = (good_cgs == pcs_sync_pkg::good_cgs_last);

    // ============================================================
    // State register
    // ============================================================

    always_ff @(posedge rx_clk) begin
        if (!reset) begin
            state       <= pcs_sync_pkg::loss_of_sync;
            rx_even     <= 1'b1;
            sync_status <= 1'b0;
            good_cgs    <= '0;
        end
        else begin
            state       <= next_state;
            rx_even     <= next_rx_even;
            sync_status <= next_sync_status;
            good_cgs    <= next_good_cgs;
        end
    end

    // ============================================================
    // Next-state logic
    // ============================================================

    always_comb begin
        // Hold by default, toggle parity every code group
        next_state       = state;
        next_rx_even     = ~rx_even;
        next_sync_status = sync_status;
        next_good_cgs    = good_cgs;

        case (state)
            // Waiting for any comma
            pcs_sync_pkg::loss_of_sync: begin
                next_sync_status = 1'b0;
                next_good_cgs    = '0;
                if (any_comma) begin
                    next_state = pcs_sync_pkg::comma_detect_1;
                end
            end

            // Data must follow each comma
            pcs_sync_pkg::comma_detect_1: begin
                next_rx_even = 1'b1;
                if (data_ok) begin
                    next_state = pcs_sync_pkg::acquire_sync_1;
                end
                else begin
                    next_state = pcs_sync_pkg::loss_of_sync;
                end
            end

            pcs_sync_pkg::acquire_sync_1: begin
                if (even_comma) begin
                    next_state = pcs_sync_pkg::comma_detect_2;
                end
                else if (!data_ok) begin
                    // Odd comma or invalid
                    next_state = pcs_sync_pkg::loss_of_sync;
                end
            end

            pcs_sync_pkg::comma_detect_2: begin
                next_rx_even = 1'b1;
                if (data_ok) begin
                    next_state = pcs_sync_pkg::acquire_sync_2;
                end
                else begin
                    next_state = pcs_sync_pkg::loss_of_sync;
                end
            end

            pcs_sync_pkg::acquire_sync_2: begin
                if (even_comma) begin
                    next_state = pcs_sync_pkg::comma_detect_3;
                end
                else if (!data_ok) begin
                    next_state = pcs_sync_pkg::loss_of_sync;
                end
            end

            // Third comma seen; one more data code group to lock
            pcs_sync_pkg::comma_detect_3: begin
                next_rx_even = 1'b1;
                if (data_ok) begin
                    next_state = pcs_sync_pkg::sync_acquired_1;
                end
                else begin
                    next_state = pcs_sync_pkg::loss_of_sync;
                end
            end

            // Locked with no outstanding errors
            pcs_sync_pkg::sync_acquired_1: begin
                next_sync_status = 1'b1;
                if (!cg_good) begin
                    next_state    = pcs_sync_pkg::sync_acquired_2;
                    next_good_cgs = '0;
                end
            end

            // One error outstanding
            pcs_sync_pkg::sync_acquired_2: begin
                if (cg_good) begin
                    next_state    = pcs_sync_pkg::sync_acquired_2a;
                    next_good_cgs = pcs_sync_pkg::good_cnt_t'(1);
                end
                else begin
                    next_state    = pcs_sync_pkg::sync_acquired_3;
                    next_good_cgs = '0;
                end
            end

            pcs_sync_pkg::sync_acquired_2a: begin
                if (cg_good && run_done) begin
                    next_state    = pcs_sync_pkg::sync_acquired_1;
                    next_good_cgs = '0;
                end
                else if (cg_good) begin
                    next_good_cgs = good_cgs + 1'b1;
                end
                else begin
                    next_state    = pcs_sync_pkg::sync_acquired_3;
                    next_good_cgs = '0;
                end
            end

            // Two errors outstanding
            pcs_sync_pkg::sync_acquired_3: begin
                if (cg_good) begin
                    next_state    = pcs_sync_pkg::sync_acquired_3a;
                    next_good_cgs = pcs_sync_pkg::good_cnt_t'(1);
                end
                else begin
                    next_state    = pcs_sync_pkg::sync_acquired_4;
                    next_good_cgs = '0;
                end
            end

            pcs_sync_pkg::sync_acquired_3a: begin
                if (cg_good && run_done) begin
                    next_state    = pcs_sync_pkg::sync_acquired_2;
                    next_good_cgs = '0;
                end
                else if (cg_good) begin
                    next_good_cgs = good_cgs + 1'b1;
                end
                else begin
                    next_state    = pcs_sync_pkg::sync_acquired_4;
                    next_good_cgs = '0;
                end
            end

            // Three errors outstanding; next bad one drops the link
            pcs_sync_pkg::sync_acquired_4: begin
                if (cg_good) begin
                    next_state    = pcs_sync_pkg::sync_acquired_4a;
                    next_good_cgs = pcs_sync_pkg::good_cnt_t'(1);
                end
                else begin
                    next_state       = pcs_sync_pkg::loss_of_sync;
                    next_sync_status = 1'b0;
                    next_good_cgs    = '0;
                end
            end

            pcs_sync_pkg::sync_acquired_4a: begin
                if (cg_good && run_done) begin
                    next_state    = pcs_sync_pkg::sync_acquired_3;
                    next_good_cgs = '0;
                end
                else if (cg_good) begin
                    next_good_cgs = good_cgs + 1'b1;
                end
                else begin
                    next_state       = pcs_sync_pkg::loss_of_sync;
                    next_sync_status = 1'b0;
                    next_good_cgs    = '0;
                end
            end

            // Unused encodings recover to loss_of_sync
            default: begin
                next_state       = pcs_sync_pkg::loss_of_sync;
                next_sync_status = 1'b0;
                next_good_cgs    = '0;
            end
        endcase
    end

endmodule

//--- rtl/pcs_synchronizer.sv
`timescale 1ns/1ns

/* sudi is combinational from rx_code_group; only sync_status and rx_even are registered.
   A new code group is expected on every rx_clk. */
module pcs_synchronizer (
    input  logic                rx_clk,
    input  logic                reset,
    input  pcs_sync_pkg::cg_t   rx_code_group,
    output pcs_sync_pkg::sudi_t sudi,
    output logic                sync_status
);

    // Classifier result and parity from the FSM
    pcs_sync_pkg::cg_kind_t cg_kind;
    logic                   rx_even;

    // Comma / table decode
    cg_classify u_classify (
        .code_group (rx_code_group),
        .kind       (cg_kind)
    );

    // Acquisition and error ladder
    sync_fsm u_fsm (
        .rx_clk      (rx_clk),
        .reset       (reset),
        .kind        (cg_kind),
        .rx_even     (rx_even),
        .sync_status (sync_status)
    );

    // Current parity tags the code group in the same cycle
    assign sudi = {rx_even, rx_code_group};

endmodule

//--- tests/pcs_synchronizer_props.sv
`timescale 1ns/1ns

/* Bound into every pcs_synchronizer instance; sampled on rx_clk only.
   The toggle property assumes reset is not asserted while in sync. */
module pcs_synchronizer_props (
    input logic                rx_clk,
    input logic                reset,
    input pcs_sync_pkg::cg_t   rx_code_group,
    input pcs_sync_pkg::sudi_t sudi,
    input logic                sync_status
);

    // ============================================================
    // sudi properties
    // ============================================================

    // Code group passes straight through
    code_group_passthrough: assert property (
        @(posedge rx_clk) sudi.code_group == rx_code_group
    ) else $error("sudi code group differs from rx_code_group");

    // In sync every state toggles rx_even
    even_toggles_in_sync: assert property (
        @(posedge rx_clk) (sync_status && reset) |=> (sudi.even != $past(sudi.even))
    ) else $error("sudi even flag did not toggle while in sync");

    // ============================================================
    // Reset
    // ============================================================

    status_low_after_reset: assert property (
        @(posedge rx_clk) !reset |=> !sync_status
    ) else $error("sync_status not low in the first cycle after reset");

endmodule

bind pcs_synchronizer pcs_synchronizer_props u_props (
    .rx_clk        (rx_clk),
    .reset         (reset),
    .rx_code_group (rx_code_group),
    .sudi          (sudi),
    .sync_status   (sync_status)
);

//--- tests/tb_pcs_synchronizer.sv
`timescale 1ns/1ns

/* Expects sync_status to rise one edge after the edge that samples the locking data
   code group. Filler data comes only from the D-code part of the valid table. */
module tb_pcs_synchronizer;

    // Invalid code group used for every error
    localparam pcs_sync_pkg::cg_t bad_cg = 10'h000;

    // Filler pool, all valid and none a comma
    localparam pcs_sync_pkg::cg_t fill_codes [12] = '{
        pcs_sync_pkg::d0_0_rdn, pcs_sync_pkg::d1_0_rdp, pcs_sync_pkg::d2_0_rdn,
        pcs_sync_pkg::d3_0_rdp, pcs_sync_pkg::d4_0_rdn, pcs_sync_pkg::d5_0_rdp,
        pcs_sync_pkg::d6_0_rdn, pcs_sync_pkg::d7_0_rdp, pcs_sync_pkg::d8_0_rdn,
        pcs_sync_pkg::d9_0_rdp, pcs_sync_pkg::d5_6_rdn, pcs_sync_pkg::d16_2_rdp
    };

    logic                rx_clk;
    logic                reset;
    pcs_sync_pkg::cg_t   rx_code_group;
    pcs_sync_pkg::sudi_t sudi;
    logic                sync_status;

    // Stimulus table: code group, expected sync_status after its edge, check flag
    pcs_sync_pkg::cg_t tbl_cg [$];
    bit                tbl_exp [$];
    bit                tbl_chk [$];

    logic [31:0] rng;
    bit          pos_even;
    int          errors;
    int          checks;
    logic        prev_even;
    logic        prev_sync;

    pcs_synchronizer u_dut (
        .rx_clk        (rx_clk),
        .reset         (reset),
        .rx_code_group (rx_code_group),
        .sudi          (sudi),
        .sync_status   (sync_status)
    );

    initial begin
        rx_clk = 1'b0;
        forever #20 rx_clk = ~rx_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ============================================================
    // Table builders
    // ============================================================

    // pos_even follows rx_even once sync is known
    task automatic add_entry(input pcs_sync_pkg::cg_t cg, input bit exp, input bit chk);
        tbl_cg.push_back(cg);
        tbl_exp.push_back(exp);
        tbl_chk.push_back(chk);
        pos_even = !pos_even;
    endtask

    task automatic add_fill(input int n, input bit exp);
        for (int k = 0; k < n; k++) begin
            rng = lcg_next(rng);
            add_entry(fill_codes[rng[31:16] % 12], exp, 1'b1);
        end
    endtask

    // Three even commas, each followed by data; status still low after the last one
    task automatic add_acquire();
        add_entry(pcs_sync_pkg::k28_5_rdn, 1'b0, 1'b1);
        add_entry(pcs_sync_pkg::d5_6_rdn, 1'b0, 1'b1);
        add_entry(pcs_sync_pkg::k28_5_rdp, 1'b0, 1'b1);
        add_entry(pcs_sync_pkg::d16_2_rdp, 1'b0, 1'b1);
        add_entry(pcs_sync_pkg::k28_5_rdn, 1'b0, 1'b1);
        add_entry(pcs_sync_pkg::d5_6_rdn, 1'b0, 1'b1);
        // First code group after lock sits in an even position
        pos_even = 1'b1;
    endtask

    task automatic build_table();
        // No commas, no sync
        add_fill(8, 1'b0);
        add_acquire();
        add_fill(6, 1'b1);
        // One error then four good, repeated
        for (int r = 0; r < 3; r++) begin
            add_entry(bad_cg, 1'b1, 1'b1);
            add_fill(4, 1'b1);
        end
        // Three errors, twelve good climb back to the top rung
        for (int r = 0; r < 2; r++) begin
            repeat (3) add_entry(bad_cg, 1'b1, 1'b1);
            add_fill(12, 1'b1);
        end
        // Fourth error in a row drops sync
        repeat (3) add_entry(bad_cg, 1'b1, 1'b1);
        add_entry(bad_cg, 1'b0, 1'b1);
        add_fill(3, 1'b0);
        add_acquire();
        add_fill(4, 1'b1);
        // Parity alignment only
        if (!pos_even) begin
            add_entry(pcs_sync_pkg::d5_6_rdn, 1'b1, 1'b0);
        end
        // Odd comma counts as the second error
        add_entry(bad_cg, 1'b1, 1'b1);
        add_entry(pcs_sync_pkg::k28_5_rdp, 1'b1, 1'b1);
        add_entry(bad_cg, 1'b1, 1'b1);
        add_entry(bad_cg, 1'b0, 1'b1);
        add_fill(2, 1'b0);
    endtask

    // Alternates comma and data until sync_status is high
    task automatic wait_for_sync(input int max_cycles);
        int n;
        n = 0;
        while (sync_status !== 1'b1 && n < max_cycles) begin
            @(negedge rx_clk);
            if (n % 2 == 0) begin
                rx_code_group = pcs_sync_pkg::k28_5_rdn;
            end
            else begin
                rx_code_group = pcs_sync_pkg::d16_2_rdn;
            end
            @(posedge rx_clk);
            #10;
            n++;
        end
        if (sync_status !== 1'b1) begin
            $display("Timeout: sync_status stayed low for %0d cycles", max_cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        reset         = 1'b0;
        rx_code_group = bad_cg;
        rng           = 32'hca49_9b98;
        pos_even      = 1'b1;
        errors        = 0;
        checks        = 0;
        prev_even     = 1'b0;
        prev_sync     = 1'b0;
        build_table();

        repeat (2) @(negedge rx_clk);
        reset = 1'b1;
        checks++;
        if (sync_status !== 1'b0) begin
            $display("FAIL %0t: sync_status %b after reset", $time, sync_status);
            errors++;
        end
        // Parity starts even out of reset
        checks++;
        if (sudi.even !== 1'b1) begin
            $display("FAIL %0t: sudi even flag %b after reset", $time, sudi.even);
            errors++;
        end

        for (int i = 0; i < tbl_cg.size(); i++) begin
            @(negedge rx_clk);
            rx_code_group = tbl_cg[i];
            #10;
            // sudi is combinational, settled mid low phase
            checks++;
            if (sudi.code_group !== tbl_cg[i]) begin
                $display("FAIL %0t: entry %0d sudi code group %h expected %h",
                         $time, i, sudi.code_group, tbl_cg[i]);
                errors++;
            end
            if (prev_sync === 1'b1 && sync_status === 1'b1) begin
                checks++;
                if (sudi.even === prev_even) begin
                    $display("FAIL %0t: entry %0d sudi even flag did not toggle", $time, i);
                    errors++;
                end
            end
            prev_even = sudi.even;
            prev_sync = sync_status;
            @(posedge rx_clk);
            #10;
            if (tbl_chk[i]) begin
                checks++;
                if (sync_status !== tbl_exp[i]) begin
                    $display("FAIL %0t: entry %0d sync_status %b expected %b",
                             $time, i, sync_status, tbl_exp[i]);
                    errors++;
                end
            end
        end

        // Relock after the odd-comma drop
        wait_for_sync(8);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end
        else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
rtl/pcs_sync_pkg.sv
rtl/cg_classify.sv
rtl/sync_fsm.sv
rtl/pcs_synchronizer.sv
tests/pcs_synchronizer_props.sv
tests/tb_pcs_synchronizer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the synchronizer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pcs_synchronizer \
    -f filelist.f

output=$(./obj_dir/Vtb_pcs_synchronizer 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi
